//--- rtl/board_pkg.sv
// Board package
// Sizes, encodings and bundled signal types shared by the
// boot-control blocks of the board top level
package board_pkg;

  // ============================================================
  // Sizes and constants
  // ============================================================
  localparam int NUM_KEYS        = 4;
  // Kept short so simulation stays quick
  localparam int DEBOUNCE_CYCLES = 8;
  localparam int DBC_CNT_W       = $clog2(DEBOUNCE_CYCLES);

  // UART bit time in clk cycles
  localparam int BAUD_DIV        = 16;
  localparam int BAUD_CNT_W      = $clog2(BAUD_DIV);

  localparam int BOOT_PC_W       = 10;

  // ASCII "g" asks for a reply
  localparam logic [7:0] GO_BYTE = 8'h67;

  // ============================================================
  // Types
  // ============================================================
  typedef enum logic [2:0] {
    IDLE,
    SEND_HI,
    WAIT_HI,
    SEND_LO,
    WAIT_LO
  } boot_state_t;

  // Debounced key outputs, one bit per key
  typedef struct packed {
    logic [NUM_KEYS-1:0] level;
    logic [NUM_KEYS-1:0] edj;
    logic [NUM_KEYS-1:0] rise;
    logic [NUM_KEYS-1:0] fall;
  } key_events_t;

  // Nibbles for the six digits, d5 leftmost
  typedef struct packed {
    logic [3:0] d5;
    logic [3:0] d4;
    logic [3:0] d3;
    logic [3:0] d2;
    logic [3:0] d1;
    logic [3:0] d0;
  } hex_digits_t;

  // Active-low segment patterns, bit 6 is segment g
  typedef struct packed {
    logic [6:0] hex5;
    logic [6:0] hex4;
    logic [6:0] hex3;
    logic [6:0] hex2;
    logic [6:0] hex1;
    logic [6:0] hex0;
  } hex_segs_t;

endpackage : board_pkg

//--- rtl/debouncer.sv
// Key debouncer
// Synchronises one push key and accepts a new level only after it
// has been stable for DEBOUNCE_CYCLES, with one-cycle edge pulses
module debouncer (
  input  logic clk,
  input  logic rst_n,
  input  logic in,
  output logic out,
  output logic edj,
  output logic rise,
  output logic fall
);

  import board_pkg::*;

  logic [1:0]           sync;
  logic [DBC_CNT_W-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Keys idle high, so start as not pressed
      sync <= 2'b11;
      cnt  <= '0;
      out  <= 1'b1;
      edj  <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
    end else begin
      sync <= {sync[0], in};
      edj  <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;

      if (sync[1] == out) begin
        // Agreement restarts the count
        cnt <= '0;
      end else if (cnt == DBC_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
        cnt  <= '0;
        out  <= sync[1];
        edj  <= 1'b1;
        rise <= sync[1];
        fall <= ~sync[1];
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule : debouncer

//--- rtl/reset_ctrl.sv
// System reset generator
// Power-on reset clears at once, the reset key and PLL lock clear
// on the next clock; release comes two clocks after all are high
module reset_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic key_rst_n,
  input  logic locked,
  output logic sys_rst_n
);

  logic [1:0] rst_sr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sr <= 2'b00;
    end else if (!key_rst_n || !locked) begin
      rst_sr <= 2'b00;
    end else begin
      rst_sr <= {rst_sr[0], 1'b1};
    end
  end

  assign sys_rst_n = rst_sr[1];

endmodule : reset_ctrl

//--- rtl/uart_tx.sv
// UART transmitter, 8N1
// Holds a requested frame while cts is high, then sends start bit,
// eight data bits LSB first and stop bit
module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_data,
  input  logic       cts,
  output logic       tx_busy,
  output logic       tx
);

  import board_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_WAIT,
    TX_SEND
  } tx_state_t;

  tx_state_t             state;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [3:0]            bit_cnt;
  // Stop, data and start bits, shifted out from bit 0
  logic [9:0]            shreg;

  always_ff @(posedge clk) begin
    if (state == TX_IDLE && tx_start) begin
      shreg <= {1'b1, tx_data, 1'b0};
    end else if ((state == TX_WAIT && !cts) ||
                 (state == TX_SEND && baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1))) begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= TX_IDLE;
      tx_busy  <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (tx_start) begin
            tx_busy <= 1'b1;
            state   <= TX_WAIT;
          end
        end
        // Back-pressure, the frame is held here
        TX_WAIT: begin
          if (!cts) begin
            tx       <= shreg[0];
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
              tx      <= 1'b1;
              tx_busy <= 1'b0;
              state   <= TX_IDLE;
            end else begin
              tx      <= shreg[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule : uart_tx

//--- rtl/uart_rx.sv
// 8N1 UART receiver
// Finds the start edge, samples each bit at mid-bit and checks the
// stop bit. A bad stop bit drops the byte and sets a sticky error
module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_data,
  output logic       frame_err
);

  import board_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t             state;
  logic [1:0]            rx_sync;
  logic                  rx_prev;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [2:0]            bit_cnt;
  logic [7:0]            shreg;
  logic                  line;
  logic                  bit_end;

  assign line    = rx_sync[1];
  assign bit_end = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  // Received bits and the output byte
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) begin
      shreg <= {line, shreg[7:1]};
    end
    if (state == RX_STOP && bit_end && line) begin
      rx_data <= shreg;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      rx_sync   <= 2'b11;
      rx_prev   <= 1'b1;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[0], rx};
      rx_prev  <= line;
      rx_valid <= 1'b0;

      case (state)
        RX_IDLE: begin
          if (rx_prev && !line) begin
            baud_cnt <= '0;
            state    <= RX_START;
          end
        end
        // Confirm the start bit is still low half a bit in
        RX_START: begin
          if (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1)) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= line ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            baud_cnt <= '0;
            state    <= RX_IDLE;
            if (line) begin
              rx_valid <= 1'b1;
            end else begin
              frame_err <= 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule : uart_rx

//--- rtl/boot_ctrl.sv
// Boot controller
// Latches the boot address on a go event and replies with it as two
// bytes; also keeps the reply count and the last received byte
module boot_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         go,
  input  logic [board_pkg::BOOT_PC_W-1:0] sw,
  input  logic                         tx_busy,
  output logic                         tx_start,
  output logic [7:0]                   tx_data,
  input  logic                         rx_valid,
  input  logic [7:0]                   rx_data,
  output logic                         rts,
  output board_pkg::hex_digits_t       digits
);

  import board_pkg::*;

  boot_state_t          state;
  logic [BOOT_PC_W-1:0] pc;
  logic [3:0]           count;
  logic [7:0]           last_rx;
  logic                 start_ev;

  // Key 0 or a "g" from the host
  assign start_ev = go || (rx_valid && rx_data == GO_BYTE);

  assign tx_start = ((state == SEND_HI) || (state == SEND_LO)) && !tx_busy;
  assign tx_data  = (state == SEND_HI) ? {6'b0, pc[9:8]} : pc[7:0];
  assign rts      = (state != IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      pc      <= '0;
      count   <= '0;
      last_rx <= '0;
    end else begin
      if (rx_valid) begin
        last_rx <= rx_data;
      end

      case (state)
        IDLE: begin
          if (start_ev) begin
            pc    <= sw;
            state <= SEND_HI;
          end
        end
        SEND_HI: if (!tx_busy) state <= WAIT_HI;
        WAIT_HI: if (!tx_busy) state <= SEND_LO;
        SEND_LO: if (!tx_busy) state <= WAIT_LO;
        WAIT_LO: begin
          if (!tx_busy) begin
            count <= count + 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Display layout: count, address, last byte
  assign digits.d5 = count;
  assign digits.d4 = {2'b00, pc[9:8]};
  assign digits.d3 = pc[7:4];
  assign digits.d2 = pc[3:0];
  assign digits.d1 = last_rx[7:4];
  assign digits.d0 = last_rx[3:0];

endmodule : boot_ctrl

//--- rtl/hex_display.sv
// Seven-segment decoder
// Turns six hex nibbles into active-low segment patterns
module hex_display (
  input  board_pkg::hex_digits_t digits,
  output board_pkg::hex_segs_t   segs
);

  // Bit order gfedcba, a lit segment is 0
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0:    seg7 = 7'b1000000;
      4'h1:    seg7 = 7'b1111001;
      4'h2:    seg7 = 7'b0100100;
      4'h3:    seg7 = 7'b0110000;
      4'h4:    seg7 = 7'b0011001;
      4'h5:    seg7 = 7'b0010010;
      4'h6:    seg7 = 7'b0000010;
      4'h7:    seg7 = 7'b1111000;
      4'h8:    seg7 = 7'b0000000;
      4'h9:    seg7 = 7'b0010000;
      4'hA:    seg7 = 7'b0001000;
      4'hB:    seg7 = 7'b0000011;
      4'hC:    seg7 = 7'b1000110;
      4'hD:    seg7 = 7'b0100001;
      4'hE:    seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;
    endcase
  endfunction

  always_comb begin
    segs.hex5 = seg7(digits.d5);
    segs.hex4 = seg7(digits.d4);
    segs.hex3 = seg7(digits.d3);
    segs.hex2 = seg7(digits.d2);
    segs.hex1 = seg7(digits.d1);
    segs.hex0 = seg7(digits.d0);
  end

endmodule : hex_display

//--- rtl/board_top.sv
// Board top level
// Keys, reset generation, boot reply over UART and the
// seven-segment display of the fabric side
module board_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            locked,
  input  logic [board_pkg::NUM_KEYS-1:0]  key,
  input  logic [board_pkg::BOOT_PC_W-1:0] sw,
  input  logic                            uart_rx,
  input  logic                            uart_cts,
  output logic                            uart_tx,
  output logic                            uart_rts,
  output board_pkg::hex_segs_t            hex,
  output logic [9:0]                      ledr
);

  import board_pkg::*;

  key_events_t key_ev;
  hex_digits_t digits;
  logic        sys_rst_n;
  logic        tx_start;
  logic [7:0]  tx_data;
  logic        tx_busy;
  logic        rx_valid;
  logic [7:0]  rx_data;
  logic        frame_err;

  // ============================================================
  // Keys, on the raw reset so key 3 still works
  // ============================================================
  for (genvar i = 0; i < NUM_KEYS; i++) begin : key_dbc_loop
    debouncer dbc (
      .clk   (clk),
      .rst_n (rst_n),
      .in    (key[i]),
      .out   (key_ev.level[i]),
      .edj   (key_ev.edj[i]),
      .rise  (key_ev.rise[i]),
      .fall  (key_ev.fall[i])
    );
  end

  // Pressed key reads 0
  reset_ctrl reset_ctrl0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .key_rst_n (key_ev.level[3]),
    .locked    (locked),
    .sys_rst_n (sys_rst_n)
  );

  // ============================================================
  // Boot reply and UART
  // ============================================================
  boot_ctrl boot_ctrl0 (
    .clk      (clk),
    .rst_n    (sys_rst_n),
    .go       (key_ev.fall[0]),
    .sw       (sw),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rts      (uart_rts),
    .digits   (digits)
  );

  uart_tx uart_tx0 (
    .clk      (clk),
    .rst_n    (sys_rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .cts      (uart_cts),
    .tx_busy  (tx_busy),
    .tx       (uart_tx)
  );

  uart_rx uart_rx0 (
    .clk       (clk),
    .rst_n     (sys_rst_n),
    .rx        (uart_rx),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .frame_err (frame_err)
  );

  hex_display hex_display0 (
    .digits (digits),
    .segs   (hex)
  );

  assign ledr = {7'b0, frame_err, uart_rts, sys_rst_n};

endmodule : board_top

//--- bench/board_tb.sv
// Board top-level testbench
// Directed tests for reset, key debounce, boot reply over the UART,
// back-pressure, remote go, framing error and the reset key
module board_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import board_pkg::*;

  localparam int FRAME = 10 * BAUD_DIV;
  localparam int HOLD  = DEBOUNCE_CYCLES + 8;
  // Worst case for one two-byte reply including the key debounce
  localparam int REPLY = 2 * FRAME + 2 * HOLD + 40;
  localparam int TEST_CYCLES = 40 + (5 * FRAME + REPLY + HOLD) + (10 * FRAME + REPLY)
                               + (3 * FRAME + REPLY + 40) + (FRAME + 20) + (2 * HOLD + REPLY);
  localparam int MAX_CYCLES = 2 * TEST_CYCLES;

  // Active-low patterns gfedcba for 0..F
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic                 clk;
  logic                 rst_n;
  logic                 locked;
  logic [NUM_KEYS-1:0]  key;
  logic [BOOT_PC_W-1:0] sw;
  logic                 uart_rx;
  logic                 uart_cts;
  logic                 uart_tx;
  logic                 uart_rts;
  hex_segs_t            hex;
  logic [9:0]           ledr;

  // Expected display contents
  logic [3:0]  exp_count;
  logic [9:0]  exp_pc;
  logic [7:0]  exp_last;
  logic [15:0] lfsr;
  int          cycles = 0;

  board_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .locked   (locked),
    .key      (key),
    .sw       (sw),
    .uart_rx  (uart_rx),
    .uart_cts (uart_cts),
    .uart_tx  (uart_tx),
    .uart_rts (uart_rts),
    .hex      (hex),
    .ledr     (ledr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      abort_run($sformatf("Timeout: no result after %0d clock cycles", MAX_CYCLES));
    end
  end

  // ============================================================
  // Helpers
  // ============================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    assert (act === exp)
      else abort_run($sformatf("Fail at time %0t: %s expected %b, got %b",
                               $time, name, exp, act));
  endtask

  task automatic compare_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
    assert (act === exp)
      else abort_run($sformatf("Fail at time %0t: %s expected %h, got %h",
                               $time, name, exp, act));
  endtask

  task automatic verify_display();
    compare_byte("hex5", {1'b0, hex.hex5}, {1'b0, SEG_TABLE[exp_count]});
    compare_byte("hex4", {1'b0, hex.hex4}, {1'b0, SEG_TABLE[{2'b00, exp_pc[9:8]}]});
    compare_byte("hex3", {1'b0, hex.hex3}, {1'b0, SEG_TABLE[exp_pc[7:4]]});
    compare_byte("hex2", {1'b0, hex.hex2}, {1'b0, SEG_TABLE[exp_pc[3:0]]});
    compare_byte("hex1", {1'b0, hex.hex1}, {1'b0, SEG_TABLE[exp_last[7:4]]});
    compare_byte("hex0", {1'b0, hex.hex0}, {1'b0, SEG_TABLE[exp_last[3:0]]});
  endtask

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic set_key(input int idx, input logic level, input int n);
    key[idx] = level;
    repeat (n) @(negedge clk);
  endtask

  task automatic hold_cts(input logic level, input int n);
    uart_cts = level;
    repeat (n) @(negedge clk);
  endtask

  // Host side of the link sends 8N1 with a chosen stop bit
  task automatic send_byte(input logic [7:0] data, input logic stop);
    logic [9:0] frame;
    frame = {stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
    uart_rx = 1'b1;
  endtask

  task automatic recv_byte(output logic [7:0] data);
    int waited;
    waited = 0;
    while (uart_tx !== 1'b0) begin
      if (waited == 2 * FRAME) abort_run("No start bit on uart_tx within the waiting limit");
      @(negedge clk);
      waited++;
    end
    // Middle of the start bit
    repeat (BAUD_DIV / 2) @(negedge clk);
    compare_bit("uart_tx start bit", uart_tx, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (BAUD_DIV) @(negedge clk);
      data[i] = uart_tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    compare_bit("uart_tx stop bit", uart_tx, 1'b1);
  endtask

  task automatic line_stays_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      compare_bit("uart_tx", uart_tx, 1'b1);
    end
  endtask

  task automatic wait_reply_done();
    int waited;
    waited = 0;
    while (uart_rts !== 1'b0) begin
      if (waited == FRAME) abort_run("uart_rts stayed high after the reply was sent");
      @(negedge clk);
      waited++;
    end
  endtask

  // High byte first, then low byte, then rts drops
  task automatic expect_reply(input logic [9:0] pc);
    logic [7:0] data;
    recv_byte(data);
    compare_byte("uart_tx byte 0", data, {6'b0, pc[9:8]});
    compare_bit("uart_rts", uart_rts, 1'b1);
    recv_byte(data);
    compare_byte("uart_tx byte 1", data, pc[7:0]);
    wait_reply_done();
  endtask

  // ============================================================
  // Tests
  // ============================================================
  task automatic reset_state();
    compare_bit("ledr[0]", ledr[0], 1'b1);
    compare_bit("ledr[1]", ledr[1], 1'b0);
    compare_byte("ledr[9:3]", {1'b0, ledr[9:3]}, 8'h00);
    compare_bit("uart_tx", uart_tx, 1'b1);
    compare_bit("uart_rts", uart_rts, 1'b0);
    verify_display();
    locked = 1'b0;
    repeat (4) @(negedge clk);
    compare_bit("ledr[0]", ledr[0], 1'b0);
    locked = 1'b1;
    repeat (3) @(negedge clk);
    compare_bit("ledr[0]", ledr[0], 1'b1);
  endtask

  task automatic debounce_and_go();
    logic [15:0] r;
    draw_bits(BOOT_PC_W, r);
    sw = r[9:0];
    // Glitch shorter than the debounce time
    set_key(0, 1'b0, DEBOUNCE_CYCLES - 3);
    set_key(0, 1'b1, 0);
    line_stays_idle(4 * FRAME);
    compare_bit("uart_rts", uart_rts, 1'b0);
    set_key(0, 1'b0, 2);
    expect_reply(sw);
    set_key(0, 1'b1, HOLD);
    exp_pc    = sw;
    exp_count = exp_count + 1'b1;
    verify_display();
    line_stays_idle(FRAME);
  endtask

  task automatic back_pressure();
    logic [15:0] r;
    logic [9:0]  pc;
    draw_bits(BOOT_PC_W, r);
    sw = r[9:0];
    pc = r[9:0];
    hold_cts(1'b1, 0);
    set_key(0, 1'b0, HOLD);
    compare_bit("uart_rts", uart_rts, 1'b1);
    compare_bit("ledr[1]", ledr[1], 1'b1);
    // Switches move while the reply is held back
    sw = ~pc;
    line_stays_idle(10 * FRAME);
    compare_bit("uart_rts", uart_rts, 1'b1);
    hold_cts(1'b0, 0);
    expect_reply(pc);
    set_key(0, 1'b1, HOLD);
    exp_pc    = pc;
    exp_count = exp_count + 1'b1;
    verify_display();
  endtask

  task automatic remote_go();
    logic [15:0] r;
    logic [7:0]  data;
    data = GO_BYTE;
    while (data == GO_BYTE || data == exp_last) begin
      draw_bits(8, r);
      data = r[7:0];
    end
    send_byte(data, 1'b1);
    repeat (4) @(negedge clk);
    exp_last = data;
    verify_display();
    compare_bit("uart_rts", uart_rts, 1'b0);
    line_stays_idle(FRAME);
    draw_bits(BOOT_PC_W, r);
    sw = r[9:0];
    fork
      send_byte(GO_BYTE, 1'b1);
      expect_reply(sw);
    join
    exp_last  = GO_BYTE;
    exp_pc    = sw;
    exp_count = exp_count + 1'b1;
    verify_display();
  endtask

  task automatic framing_error();
    logic [15:0] r;
    r = {8'h00, exp_last};
    while (r[7:0] == exp_last) begin
      draw_bits(8, r);
    end
    compare_bit("ledr[2]", ledr[2], 1'b0);
    send_byte(r[7:0], 1'b0);
    repeat (4) @(negedge clk);
    compare_bit("ledr[2]", ledr[2], 1'b1);
    compare_byte("ledr[9:3]", {1'b0, ledr[9:3]}, 8'h00);
    compare_bit("uart_rts", uart_rts, 1'b0);
    verify_display();
  endtask

  task automatic reset_key();
    logic [15:0] r;
    set_key(3, 1'b0, HOLD);
    compare_bit("ledr[0]", ledr[0], 1'b0);
    compare_bit("ledr[2]", ledr[2], 1'b0);
    exp_count = '0;
    exp_pc    = '0;
    exp_last  = '0;
    verify_display();
    set_key(3, 1'b1, HOLD);
    compare_bit("ledr[0]", ledr[0], 1'b1);
    draw_bits(BOOT_PC_W, r);
    sw = r[9:0];
    set_key(0, 1'b0, 2);
    expect_reply(sw);
    set_key(0, 1'b1, HOLD);
    exp_pc    = sw;
    exp_count = 4'd1;
    verify_display();
  endtask

  initial begin
    rst_n     = 1'b0;
    locked    = 1'b1;
    key       = '1;
    sw        = '0;
    uart_rx   = 1'b1;
    uart_cts  = 1'b0;
    lfsr      = 16'd4096;
    exp_count = '0;
    exp_pc    = '0;
    exp_last  = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);

    reset_state();
    debounce_and_go();
    back_pressure();
    remote_go();
    framing_error();
    reset_key();

    $display("TEST PASS");
    $finish;
  end

endmodule : board_tb

//--- sim.f
rtl/board_pkg.sv
rtl/debouncer.sv
rtl/reset_ctrl.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/boot_ctrl.sv
rtl/hex_display.sv
rtl/board_top.sv
bench/board_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the board testbench with Verilator, run it and search the log
# for the pass message
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module board_tb -f sim.f -o board_sim \
  && ./obj_dir/board_sim | tee sim.log \
  || echo "Build or run stopped early"
grep -q "TEST PASS" sim.log 2>/dev/null && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
